// ==== files.f ====
logic/rename_pkg.sv
logic/rename_map.sv
logic/free_list.sv
logic/reorder_buffer.sv
logic/retire_map.sv
logic/rename_core.sv
verification/tb_clock.sv
verification/tb_rename_core.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_rename_core -f files.f
out=$(./obj_dir/Vtb_rename_core 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "all tests passed"

// ==== verification/tb_rename_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rename_core
import rename_pkg::*;
();

    localparam int N_INSTR      = 2000;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;

    logic       clk;
    logic       rst;
    logic       disp_valid_i, disp_we_i, cdb_valid_i;
    arch_reg_t  disp_rd_i, disp_rs1_i, disp_rs2_i;
    rob_idx_t   cdb_rob_idx_i, ren_rob_idx_o, commit_rob_idx_o;
    logic       ren_valid_o, ren_ps1_ready_o, ren_ps2_ready_o;
    logic       credit_o, commit_valid_o, commit_we_o;
    arch_reg_t  commit_rd_o;
    phys_reg_t  ren_pd_o, ren_ps1_o, ren_ps2_o, commit_pd_o, commit_old_pd_o;

    // reference model
    phys_reg_t              spec_m [ARCH_REGS];
    phys_reg_t              rrat_m [ARCH_REGS];
    logic [PHYS_REGS-1:0]   ready_m;
    phys_reg_t              fl_q [$];
    rob_idx_t               order_q [$];    // rob slots in dispatch order
    logic [ROB_DEPTH-1:0]   we_m, done_m, issued_m, seen_m;
    arch_reg_t              rd_m [ROB_DEPTH];
    phys_reg_t              pd_m [ROB_DEPTH];
    rob_idx_t               tail_m;
    int                     credits;
    int                     n_disp;
    integer                 seed;

    // expected outputs for the cycle after an edge
    logic           exp_ren, exp_commit;
    logic [24:0]    exp_ren_f;      // idx, pd, ps1, ps2, rdy1, rdy2
    logic [22:0]    exp_commit_f;   // idx, we, rd, pd, old pd

    tb_clock tb_clock_i (.clk_o(clk));

    rename_core rename_core_i (.*);

    task automatic report_mismatch(input string msg);
        $display("mismatch at time %0t: %s", $time, msg);
        $display("tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    // state change at one rising edge from the sampled inputs
    task automatic model_edge();
        logic       writer;
        rob_idx_t   h;
        phys_reg_t  pd;
        phys_reg_t  ps1;
        phys_reg_t  ps2;
        phys_reg_t  old_pd;
        exp_commit = order_q.size() != 0 && done_m[order_q[0]]; // done before this edge
        if (exp_commit) begin
            h            = order_q.pop_front();
            old_pd       = rrat_m[rd_m[h]];
            exp_commit_f = {h, we_m[h], rd_m[h], pd_m[h], old_pd};
            if (we_m[h]) begin
                rrat_m[rd_m[h]] = pd_m[h];
                fl_q.push_back(old_pd);
            end
        end
        if (cdb_valid_i) begin
            done_m[cdb_rob_idx_i] = 1'b1;
            if (we_m[cdb_rob_idx_i]) begin
                ready_m[pd_m[cdb_rob_idx_i]] = 1'b1; // visible to this edge's lookup
            end
        end
        exp_ren = disp_valid_i;
        if (disp_valid_i) begin
            writer    = disp_we_i && (disp_rd_i != '0);
            pd        = writer ? fl_q[0] : '0;
            ps1       = spec_m[disp_rs1_i]; // before its own write
            ps2       = spec_m[disp_rs2_i];
            exp_ren_f = {tail_m, pd, ps1, ps2,
                         (ps1 == '0) || ready_m[ps1], (ps2 == '0) || ready_m[ps2]};
            if (writer) begin
                pd                = fl_q.pop_front();
                spec_m[disp_rd_i] = pd;
                ready_m[pd]       = 1'b0;
            end
            we_m[tail_m]     = writer;
            done_m[tail_m]   = 1'b0;
            issued_m[tail_m] = 1'b0;
            seen_m[tail_m]   = 1'b0;
            rd_m[tail_m] = disp_rd_i;
            pd_m[tail_m] = pd;
            order_q.push_back(tail_m);
            tail_m = tail_m + 1'b1;
        end
    endtask

    task automatic drive_inputs();
        logic [31:0]    rnd;
        rob_idx_t       cands [$];
        int             pick;
        rnd = $random(seed);
        disp_valid_i <= 1'b0;
        if (credits > 0 && n_disp < N_INSTR && rnd[0]) begin
            disp_valid_i <= 1'b1;
            disp_we_i    <= rnd[1];
            disp_rd_i    <= rnd[6:2];
            disp_rs1_i   <= rnd[11:7];
            disp_rs2_i   <= rnd[16:12];
            credits       = credits - 1;
            n_disp        = n_disp + 1;
        end
        foreach (order_q[i]) begin
            if (seen_m[order_q[i]] && !issued_m[order_q[i]]) begin
                cands.push_back(order_q[i]);
            end
        end
        cdb_valid_i <= 1'b0;
        if (cands.size() != 0 && rnd[18:17] != 2'b00) begin
            pick                  = int'(rnd[31:20]) % cands.size();
            cdb_valid_i          <= 1'b1;
            cdb_rob_idx_i        <= cands[pick];
            issued_m[cands[pick]] = 1'b1;
        end
    endtask

    task automatic check_outputs();
        logic [24:0]    got_ren;
        logic [22:0]    got_commit;
        got_ren    = {ren_rob_idx_o, ren_pd_o, ren_ps1_o, ren_ps2_o,
                      ren_ps1_ready_o, ren_ps2_ready_o};
        got_commit = {commit_rob_idx_o, commit_we_o, commit_rd_o, commit_pd_o, commit_old_pd_o};
        assert (ren_valid_o === exp_ren && commit_valid_o === exp_commit && credit_o === exp_commit)
            else report_mismatch($sformatf("ren/commit/credit valid %b%b%b, expected %b%b%b",
                ren_valid_o, commit_valid_o, credit_o, exp_ren, exp_commit, exp_commit));
        if (exp_ren) begin
            assert (got_ren === exp_ren_f)
                else report_mismatch($sformatf("rename fields %h, expected %h",
                    got_ren, exp_ren_f));
            seen_m[exp_ren_f[24:20]] = 1'b1; // now eligible for completion
        end
        if (exp_commit) begin
            assert (got_commit === exp_commit_f)
                else report_mismatch($sformatf("commit fields %h, expected %h",
                    got_commit, exp_commit_f));
        end
        if (credit_o) begin
            credits = credits + 1;
        end
    endtask

    initial begin
        seed = 32'ha99e_b0b9;
        rst  = 1'b1;
        {disp_valid_i, disp_we_i, cdb_valid_i} = '0;
        {disp_rd_i, disp_rs1_i, disp_rs2_i, cdb_rob_idx_i} = '0;
        credits = ROB_DEPTH;
        n_disp  = 0;
        tail_m  = '0;
        for (int i = 0; i < PHYS_REGS; i++) begin
            ready_m[i] = (i < ARCH_REGS);
            if (i < ARCH_REGS) begin
                spec_m[i] = phys_reg_t'(i);
                rrat_m[i] = phys_reg_t'(i);
            end else begin
                fl_q.push_back(phys_reg_t'(i)); // p32 first
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        while (n_disp < N_INSTR || order_q.size() != 0 || disp_valid_i) begin // dispatch on the inputs still pending
            @(posedge clk);
            model_edge();
            drive_inputs();
            @(negedge clk);
            check_outputs();
        end
        assert (credits == ROB_DEPTH)
            else report_mismatch($sformatf("%0d credits after drain, expected %0d",
                credits, ROB_DEPTH));
        assert (fl_q.size() == PHYS_REGS - ARCH_REGS)
            else report_mismatch($sformatf("free list holds %0d after drain, expected %0d",
                fl_q.size(), PHYS_REGS - ARCH_REGS));
        $display("all tests passed");
        $finish;
    end

    // watchdog allows 40 cycles per instruction
    initial begin
        #(N_INSTR * 40 * CLK_PERIOD);
        $display("timeout: the core did not drain within %0d cycles", N_INSTR * 40);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

endmodule : tb_rename_core

`default_nettype wire

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk_o
);

    localparam int HALF_PERIOD = 2; // 4 ns period

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

endmodule : tb_clock

`default_nettype wire

// ==== logic/rename_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_core
import rename_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,

    input  wire logic      disp_valid_i,
    input  wire logic      disp_we_i,
    input  wire arch_reg_t disp_rd_i,
    input  wire arch_reg_t disp_rs1_i,
    input  wire arch_reg_t disp_rs2_i,

    input  wire logic      cdb_valid_i,
    input  wire rob_idx_t  cdb_rob_idx_i,

    output logic           ren_valid_o,
    output rob_idx_t       ren_rob_idx_o,
    output phys_reg_t      ren_pd_o,
    output phys_reg_t      ren_ps1_o,
    output phys_reg_t      ren_ps2_o,
    output logic           ren_ps1_ready_o,
    output logic           ren_ps2_ready_o,

    output logic           credit_o,
    output logic           commit_valid_o,
    output rob_idx_t       commit_rob_idx_o,
    output logic           commit_we_o,
    output arch_reg_t      commit_rd_o,
    output phys_reg_t      commit_pd_o,
    output phys_reg_t      commit_old_pd_o
);

    logic       disp_writer;
    phys_reg_t  fl_head_pd;
    phys_reg_t  alloc_pd;
    rob_idx_t   disp_rob_idx;
    phys_reg_t  ps1;
    phys_reg_t  ps2;
    logic       ps1_ready;
    logic       ps2_ready;
    logic       wakeup_valid;
    phys_reg_t  wakeup_pd;
    logic       retire;
    logic       retire_we;
    arch_reg_t  retire_rd;
    phys_reg_t  retire_pd;
    phys_reg_t  old_pd;

    assign disp_writer = disp_we_i && (disp_rd_i != '0); // x0 never renamed
    assign alloc_pd    = disp_writer ? fl_head_pd : '0;

    rename_map rename_map_i (
        .clk(clk), .rst(rst),
        .alloc_valid_i(disp_valid_i && disp_writer),
        .alloc_rd_i(disp_rd_i), .alloc_pd_i(alloc_pd),
        .rs1_i(disp_rs1_i), .rs2_i(disp_rs2_i),
        .wakeup_valid_i(wakeup_valid), .wakeup_pd_i(wakeup_pd),
        .ps1_o(ps1), .ps2_o(ps2),
        .ps1_ready_o(ps1_ready), .ps2_ready_o(ps2_ready)
    );

    free_list free_list_i (
        .clk(clk), .rst(rst),
        .pop_i(disp_valid_i && disp_writer),
        .push_i(retire && retire_we), .push_pd_i(old_pd), // old mapping returns
        .head_pd_o(fl_head_pd)
    );

    reorder_buffer reorder_buffer_i (
        .clk(clk), .rst(rst),
        .disp_valid_i(disp_valid_i), .disp_we_i(disp_writer),
        .disp_rd_i(disp_rd_i), .disp_pd_i(alloc_pd), .disp_rob_idx_o(disp_rob_idx),
        .cdb_valid_i(cdb_valid_i), .cdb_rob_idx_i(cdb_rob_idx_i),
        .wakeup_valid_o(wakeup_valid), .wakeup_pd_o(wakeup_pd),
        .retire_o(retire), .retire_we_o(retire_we),
        .retire_rd_o(retire_rd), .retire_pd_o(retire_pd),
        .credit_o(credit_o), .commit_valid_o(commit_valid_o),
        .commit_rob_idx_o(commit_rob_idx_o)
    );

    retire_map retire_map_i (
        .clk(clk), .rst(rst),
        .retire_i(retire), .retire_we_i(retire_we),
        .retire_rd_i(retire_rd), .retire_pd_i(retire_pd),
        .old_pd_o(old_pd)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            ren_valid_o <= 1'b0;
        end else begin
            ren_valid_o <= disp_valid_i;
        end
    end

    // rename results and commit fields, one cycle behind
    always_ff @(posedge clk) begin
        ren_rob_idx_o   <= disp_rob_idx;
        ren_pd_o        <= alloc_pd;
        ren_ps1_o       <= ps1;
        ren_ps2_o       <= ps2;
        ren_ps1_ready_o <= ps1_ready;
        ren_ps2_ready_o <= ps2_ready;
        commit_we_o     <= retire_we;
        commit_rd_o     <= retire_rd;
        commit_pd_o     <= retire_pd;
        commit_old_pd_o <= old_pd;
    end

endmodule : rename_core

`default_nettype wire

// ==== logic/retire_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module retire_map
import rename_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,

    input  wire logic      retire_i,
    input  wire logic      retire_we_i,
    input  wire arch_reg_t retire_rd_i,
    input  wire phys_reg_t retire_pd_i,

    output phys_reg_t      old_pd_o
);

    phys_reg_t  rrat [ARCH_REGS]; // committed mapping

    // mapping being replaced, freed by the caller
    assign old_pd_o = rrat[retire_rd_i];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                rrat[i] <= phys_reg_t'(i);
            end
        end else if (retire_i && retire_we_i) begin
            rrat[retire_rd_i] <= retire_pd_i;
        end
    end

endmodule : retire_map

`default_nettype wire

// ==== logic/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer
import rename_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,

    input  wire logic      disp_valid_i,
    input  wire logic      disp_we_i,
    input  wire arch_reg_t disp_rd_i,
    input  wire phys_reg_t disp_pd_i,
    output rob_idx_t       disp_rob_idx_o,

    input  wire logic      cdb_valid_i,
    input  wire rob_idx_t  cdb_rob_idx_i,
    output logic           wakeup_valid_o,
    output phys_reg_t      wakeup_pd_o,

    output logic           retire_o,
    output logic           retire_we_o,
    output arch_reg_t      retire_rd_o,
    output phys_reg_t      retire_pd_o,

    output logic           credit_o,
    output logic           commit_valid_o,
    output rob_idx_t       commit_rob_idx_o
);

    typedef logic [$clog2(ROB_DEPTH):0] rob_count_t;

    logic [ROB_DEPTH-1:0]   busy;   // slot allocated
    logic [ROB_DEPTH-1:0]   done;   // completion seen
    logic [ROB_DEPTH-1:0]   ent_we; // writer flag
    arch_reg_t              ent_rd [ROB_DEPTH];
    phys_reg_t              ent_pd [ROB_DEPTH];

    rob_idx_t               rob_head;
    rob_idx_t               rob_tail;
    rob_count_t             rob_count;

    assign disp_rob_idx_o = rob_tail;

    // completion forwards its destination to the ready table
    assign wakeup_valid_o = cdb_valid_i && ent_we[cdb_rob_idx_i];
    assign wakeup_pd_o    = ent_pd[cdb_rob_idx_i];

    // head retires once done
    assign retire_o    = busy[rob_head] && done[rob_head];
    assign retire_we_o = ent_we[rob_head];
    assign retire_rd_o = ent_rd[rob_head];
    assign retire_pd_o = ent_pd[rob_head];

    // entry payload, no reset
    always_ff @(posedge clk) begin
        if (disp_valid_i) begin
            ent_we[rob_tail] <= disp_we_i;
            ent_rd[rob_tail] <= disp_rd_i;
            ent_pd[rob_tail] <= disp_pd_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= '0;
            done      <= '0;
            rob_head  <= '0;
            rob_tail  <= '0;
            rob_count <= '0;
        end else begin
            if (disp_valid_i) begin
                busy[rob_tail] <= 1'b1;
                done[rob_tail] <= 1'b0;
                rob_tail       <= rob_tail + 1'b1;
            end
            if (cdb_valid_i) begin
                done[cdb_rob_idx_i] <= 1'b1;
            end
            if (retire_o) begin
                busy[rob_head] <= 1'b0;
                done[rob_head] <= 1'b0;
                rob_head       <= rob_head + 1'b1;
            end
            rob_count <= rob_count + rob_count_t'(disp_valid_i) - rob_count_t'(retire_o);
        end
    end

    // commit strobe and credit return, one cycle after retirement
    always_ff @(posedge clk) begin
        if (rst) begin
            credit_o       <= 1'b0;
            commit_valid_o <= 1'b0;
        end else begin
            credit_o       <= retire_o;
            commit_valid_o <= retire_o;
        end
    end

    always_ff @(posedge clk) begin
        commit_rob_idx_o <= rob_head;
    end

    // sender must hold a credit for every dispatch
    no_disp_full_a: assert property (
        @(posedge clk) disable iff (rst)
        disp_valid_i |-> (rob_count != rob_count_t'(ROB_DEPTH))
    ) else $error("dispatch without a credit");

    cdb_target_live_a: assert property (
        @(posedge clk) disable iff (rst)
        cdb_valid_i |-> (busy[cdb_rob_idx_i] && !done[cdb_rob_idx_i])
    ) else $error("completion of an idle or already completed entry");

endmodule : reorder_buffer

`default_nettype wire

// ==== logic/free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

module free_list
import rename_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,

    input  wire logic      pop_i,
    input  wire logic      push_i,
    input  wire phys_reg_t push_pd_i,

    output phys_reg_t      head_pd_o
);

    typedef logic [$clog2(PHYS_REGS)-1:0] fl_ptr_t;
    typedef logic [$clog2(PHYS_REGS):0]   fl_count_t;

    phys_reg_t  fl_mem [PHYS_REGS];
    fl_ptr_t    fl_head;
    fl_ptr_t    fl_tail;
    fl_count_t  fl_count;

    assign head_pd_o = fl_mem[fl_head]; // next register to hand out

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PHYS_REGS - ARCH_REGS; i++) begin
                fl_mem[i] <= phys_reg_t'(ARCH_REGS + i); // p32..p63
            end
            fl_head  <= '0;
            fl_tail  <= fl_ptr_t'(PHYS_REGS - ARCH_REGS);
            fl_count <= fl_count_t'(PHYS_REGS - ARCH_REGS);
        end else begin
            if (push_i) begin
                fl_mem[fl_tail] <= push_pd_i;
                fl_tail         <= fl_tail + 1'b1;
            end
            if (pop_i) begin
                fl_head <= fl_head + 1'b1;
            end
            fl_count <= fl_count + fl_count_t'(push_i) - fl_count_t'(pop_i);
        end
    end

    // credits bound in-flight writers to ROB_DEPTH, so a pop always finds a register
    no_pop_empty_a: assert property (
        @(posedge clk) disable iff (rst)
        pop_i |-> (fl_count != '0)
    ) else $error("free list popped while empty");

    no_push_full_a: assert property (
        @(posedge clk) disable iff (rst)
        push_i |-> (fl_count != fl_count_t'(PHYS_REGS))
    ) else $error("free list pushed while full");

endmodule : free_list

`default_nettype wire

// ==== logic/rename_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_map
import rename_pkg::*;
(
    input  wire logic      clk,
    input  wire logic      rst,

    input  wire logic      alloc_valid_i,
    input  wire arch_reg_t alloc_rd_i,
    input  wire phys_reg_t alloc_pd_i,

    input  wire arch_reg_t rs1_i,
    input  wire arch_reg_t rs2_i,

    input  wire logic      wakeup_valid_i,
    input  wire phys_reg_t wakeup_pd_i,

    output phys_reg_t      ps1_o,
    output phys_reg_t      ps2_o,
    output logic           ps1_ready_o,
    output logic           ps2_ready_o
);

    phys_reg_t              spec_map [ARCH_REGS]; // speculative rat
    logic [PHYS_REGS-1:0]   ready_q;              // one bit per physical reg

    // p0 is hardwired zero, a same-cycle wakeup forwards
    function automatic logic src_ready(input phys_reg_t pr);
        logic rdy;
        rdy = (pr == '0) || ready_q[pr];
        rdy = rdy || (wakeup_valid_i && (wakeup_pd_i == pr));
        return rdy;
    endfunction

    always_comb begin
        ps1_o       = spec_map[rs1_i]; // lookup before this inst's own write
        ps2_o       = spec_map[rs2_i];
        ps1_ready_o = src_ready(ps1_o);
        ps2_ready_o = src_ready(ps2_o);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                spec_map[i] <= phys_reg_t'(i); // identity mapping
            end
            for (int i = 0; i < PHYS_REGS; i++) begin
                ready_q[i] <= (i < ARCH_REGS); // committed regs hold values
            end
        end else begin
            if (wakeup_valid_i) begin
                ready_q[wakeup_pd_i] <= 1'b1;
            end
            if (alloc_valid_i) begin
                spec_map[alloc_rd_i] <= alloc_pd_i;
                ready_q[alloc_pd_i]  <= 1'b0; // new producer pending
            end
        end
    end

    // a woken register is owned by an in-flight entry, so it cannot be on the free list
    wakeup_alloc_disjoint_a: assert property (
        @(posedge clk) disable iff (rst)
        !(wakeup_valid_i && alloc_valid_i && (wakeup_pd_i == alloc_pd_i))
    ) else $error("wakeup and allocation hit the same physical register");

endmodule : rename_map

`default_nettype wire

// ==== logic/rename_pkg.sv ====
`default_nettype none

package rename_pkg;

    // register counts; 32 rob slots against 32 spare physical registers
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;
    localparam int ROB_DEPTH = 32;

    typedef logic [$clog2(ARCH_REGS)-1:0] arch_reg_t; // x0..x31
    typedef logic [$clog2(PHYS_REGS)-1:0] phys_reg_t; // p0..p63
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;  // wraps modulo ROB_DEPTH

endpackage : rename_pkg

`default_nettype wire
